// ==== hdl/chromaUpsampler.sv ====
module chromaUpsampler (
	input logic Clock,
	input logic Resetn,
	input logic advance,
	input logic flushStep,
	input logic lineFirst,
	input logic emit,
	input yuvPkg::yuvPairT pairIn,
	output logic upValid,
	output yuvPkg::upPairT upPair
);

	// Index 0 holds the newest sample, index 3 is the window centre
	logic [5:0][7:0] uWin;
	logic [5:0][7:0] vWin;
	logic [5:0][7:0] uNext;
	logic [5:0][7:0] vNext;
	logic [7:0] uNew;
	logic [7:0] vNew;

	// Luma pairs wait three steps to meet their chroma centre
	logic [2:0][15:0] yDel;
	logic [15:0] yNew;

	function automatic logic [7:0] filterOdd(input logic [5:0][7:0] w);
		logic signed [31:0] acc;
		acc = yuvPkg::Tap0 * $signed({24'd0, w[5]})
			+ yuvPkg::Tap1 * $signed({24'd0, w[4]})
			+ yuvPkg::Tap2 * $signed({24'd0, w[3]})
			+ yuvPkg::Tap2 * $signed({24'd0, w[2]})
			+ yuvPkg::Tap1 * $signed({24'd0, w[1]})
			+ yuvPkg::Tap0 * $signed({24'd0, w[0]})
			+ yuvPkg::FilterRound;
		acc = acc >>> yuvPkg::FilterShift;
		// Negative taps can push the result outside the byte range
		if (acc < 0)
			return 8'd0;
		if (acc > 255)
			return 8'd255;
		return acc[7:0];
	endfunction

	// Flush steps repeat the newest sample for the right edge
	assign uNew = flushStep ? uWin[0] : pairIn.u;
	assign vNew = flushStep ? vWin[0] : pairIn.v;
	assign yNew = flushStep ? yDel[0] : {pairIn.y1, pairIn.y0};

	always_comb begin
		if (lineFirst) begin
			// Left edge replication
			uNext = {6{uNew}};
			vNext = {6{vNew}};
		end else begin
			uNext = {uWin[4:0], uNew};
			vNext = {vWin[4:0], vNew};
		end
	end

	always_ff @(posedge Clock) begin
		if (advance) begin
			uWin <= uNext;
			vWin <= vNext;
			yDel <= {yDel[1:0], yNew};
			if (emit) begin
				upPair.y0 <= yDel[2][7:0];
				upPair.y1 <= yDel[2][15:8];
				upPair.uEven <= uNext[3];
				upPair.vEven <= vNext[3];
				upPair.uOdd <= filterOdd(uNext);
				upPair.vOdd <= filterOdd(vNext);
			end
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn)
			upValid <= 1'b0;
		else
			upValid <= advance && emit;
	end

endmodule

// ==== hdl/colorMatrix.sv ====
module colorMatrix (
	input logic Clock,
	input logic Resetn,
	input logic upValid,
	input yuvPkg::upPairT upPair,
	output logic rgbValid,
	output yuvPkg::rgbPairT rgbData
);

	typedef struct packed {
		logic signed [31:0] y;
		logic signed [31:0] u;
		logic signed [31:0] v;
	} diffT;

	typedef struct packed {
		logic signed [31:0] luma;
		logic signed [31:0] rv;
		logic signed [31:0] gu;
		logic signed [31:0] gv;
		logic signed [31:0] bu;
	} prodT;

	logic valid1;
	logic valid2;
	diffT diffEven;
	diffT diffOdd;
	prodT prodEven;
	prodT prodOdd;

	function automatic diffT removeOffsets(input logic [7:0] y, input logic [7:0] u,
		input logic [7:0] v);
		diffT d;
		d.y = $signed({24'd0, y}) - yuvPkg::LumaOffset;
		d.u = $signed({24'd0, u}) - yuvPkg::ChromaOffset;
		d.v = $signed({24'd0, v}) - yuvPkg::ChromaOffset;
		return d;
	endfunction

	function automatic prodT formProducts(input diffT d);
		prodT p;
		p.luma = yuvPkg::CoefY * d.y;
		p.rv = yuvPkg::CoefRV * d.v;
		p.gu = yuvPkg::CoefGU * d.u;
		p.gv = yuvPkg::CoefGV * d.v;
		p.bu = yuvPkg::CoefBU * d.u;
		return p;
	endfunction

	// Saturate, then keep the integer byte of the fixed-point sum
	function automatic logic [7:0] clipChannel(input logic signed [31:0] acc);
		logic signed [31:0] scaled;
		scaled = acc >>> yuvPkg::MatrixShift;
		if (scaled < 0)
			return 8'd0;
		if (scaled > 255)
			return 8'd255;
		return scaled[7:0];
	endfunction

	function automatic yuvPkg::rgbPixelT sumPixel(input prodT p);
		yuvPkg::rgbPixelT px;
		px.r = clipChannel(p.luma + p.rv);
		px.g = clipChannel(p.luma + p.gu + p.gv);
		px.b = clipChannel(p.luma + p.bu);
		return px;
	endfunction

	always_ff @(posedge Clock) begin
		diffEven <= removeOffsets(upPair.y0, upPair.uEven, upPair.vEven);
		diffOdd <= removeOffsets(upPair.y1, upPair.uOdd, upPair.vOdd);
		prodEven <= formProducts(diffEven);
		prodOdd <= formProducts(diffOdd);
		rgbData.pixEven <= sumPixel(prodEven);
		rgbData.pixOdd <= sumPixel(prodOdd);
	end

	// Valid travels alongside the three data stages
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			rgbValid <= 1'b0;
		end else begin
			valid1 <= upValid;
			valid2 <= valid1;
			rgbValid <= valid2;
		end
	end

endmodule

// ==== hdl/lineControl.sv ====
module lineControl #(
	parameter int OutCredits = 2,
	parameter int PairCountWidth = 8
) (
	input logic Clock,
	input logic Resetn,
	input logic cfgWrite,
	input logic [PairCountWidth-1:0] cfgPairs,
	input logic notEmpty,
	input logic rgbCredit,
	output logic pop,
	output logic advance,
	output logic flushStep,
	output logic lineFirst,
	output logic emit,
	output logic lineBusy
);

	localparam int CreditWidth = $clog2(OutCredits + 1);

	yuvPkg::lineStateT state;
	logic [PairCountWidth-1:0] widthReg;
	logic [PairCountWidth-1:0] fedCount;
	logic [1:0] flushCount;
	logic [CreditWidth-1:0] creditCount;
	logic feeding;
	logic flushing;
	logic creditOk;
	logic take;

	assign feeding = state == yuvPkg::LineFeed;
	assign flushing = state == yuvPkg::LineFlush;
	assign creditOk = creditCount != '0;

	// First three pairs only prime the window
	assign emit = flushing || (feeding && fedCount >= PairCountWidth'(3));

	// An emitting step needs a free output slot before it may go
	assign advance = (feeding && notEmpty && (creditOk || !emit)) || (flushing && creditOk);
	assign pop = advance && feeding;
	assign flushStep = flushing;
	assign lineFirst = feeding && fedCount == '0;
	assign lineBusy = state != yuvPkg::LineIdle;
	assign take = advance && emit;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= yuvPkg::LineIdle;
			widthReg <= '0;
			fedCount <= '0;
			flushCount <= '0;
		end else begin
			case (state)
				yuvPkg::LineIdle: begin
					if (cfgWrite) begin
						widthReg <= cfgPairs;
						fedCount <= '0;
						flushCount <= '0;
						state <= yuvPkg::LineFeed;
					end
				end
				yuvPkg::LineFeed: begin
					if (advance) begin
						fedCount <= fedCount + 1'b1;
						if (fedCount == widthReg - 1'b1)
							state <= yuvPkg::LineFlush;
					end
				end
				yuvPkg::LineFlush: begin
					// Three repeats of the last sample drain the window
					if (advance) begin
						flushCount <= flushCount + 1'b1;
						if (flushCount == 2'd2)
							state <= yuvPkg::LineIdle;
					end
				end
				default: state <= yuvPkg::LineIdle;
			endcase
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			creditCount <= CreditWidth'(OutCredits);
		end else begin
			case ({take, rgbCredit})
				2'b10: creditCount <= creditCount - 1'b1;
				2'b01: creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

endmodule

// ==== hdl/pairFifo.sv ====
module pairFifo #(
	parameter int FifoDepth = 4
) (
	input logic Clock,
	input logic Resetn,
	input logic yuvValid,
	input yuvPkg::yuvPairT yuvData,
	input logic pop,
	output yuvPkg::yuvPairT head,
	output logic notEmpty,
	output logic yuvCredit
);

	localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int CountWidth = $clog2(FifoDepth + 1);

	yuvPkg::yuvPairT store [FifoDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;

	// Circular pointer step, depth need not be a power of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(FifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge Clock) begin
		if (yuvValid)
			store[wrPtr] <= yuvData;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			yuvCredit <= 1'b0;
		end else begin
			if (yuvValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({yuvValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Each removed pair frees one slot upstream
			yuvCredit <= pop;
		end
	end

	assign head = store[rdPtr];
	assign notEmpty = count != '0;

endmodule

// ==== hdl/yuvConvertTop.sv ====
module yuvConvertTop #(
	parameter int FifoDepth = 4,
	parameter int OutCredits = 2,
	parameter int PairCountWidth = 8
) (
	input logic Clock,
	input logic Resetn,
	input logic yuvValid,
	input yuvPkg::yuvPairT yuvData,
	output logic yuvCredit,
	input logic cfgWrite,
	input logic [PairCountWidth-1:0] cfgPairs,
	output logic lineBusy,
	output logic rgbValid,
	output yuvPkg::rgbPairT rgbData,
	input logic rgbCredit
);

	yuvPkg::yuvPairT head;
	yuvPkg::upPairT upPair;
	logic notEmpty;
	logic pop;
	logic advance;
	logic flushStep;
	logic lineFirst;
	logic emit;
	logic upValid;

	pairFifo #(
		.FifoDepth(FifoDepth)
	) u_pairFifo (
		.Clock(Clock),
		.Resetn(Resetn),
		.yuvValid(yuvValid),
		.yuvData(yuvData),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.yuvCredit(yuvCredit)
	);

	lineControl #(
		.OutCredits(OutCredits),
		.PairCountWidth(PairCountWidth)
	) u_lineControl (
		.Clock(Clock),
		.Resetn(Resetn),
		.cfgWrite(cfgWrite),
		.cfgPairs(cfgPairs),
		.notEmpty(notEmpty),
		.rgbCredit(rgbCredit),
		.pop(pop),
		.advance(advance),
		.flushStep(flushStep),
		.lineFirst(lineFirst),
		.emit(emit),
		.lineBusy(lineBusy)
	);

	// Popped head feeds the window in the same cycle as the advance
	chromaUpsampler u_chromaUpsampler (
		.Clock(Clock),
		.Resetn(Resetn),
		.advance(advance),
		.flushStep(flushStep),
		.lineFirst(lineFirst),
		.emit(emit),
		.pairIn(head),
		.upValid(upValid),
		.upPair(upPair)
	);

	colorMatrix u_colorMatrix (
		.Clock(Clock),
		.Resetn(Resetn),
		.upValid(upValid),
		.upPair(upPair),
		.rgbValid(rgbValid),
		.rgbData(rgbData)
	);

endmodule

// ==== hdl/yuvPkg.sv ====
package yuvPkg;

	// One 4:2:2 pair as it arrives, u and v belong to the even pixel
	typedef struct packed {
		logic [7:0] y0;
		logic [7:0] y1;
		logic [7:0] u;
		logic [7:0] v;
	} yuvPairT;

	// Pair after upsampling, full chroma for both pixels
	typedef struct packed {
		logic [7:0] y0;
		logic [7:0] y1;
		logic [7:0] uEven;
		logic [7:0] vEven;
		logic [7:0] uOdd;
		logic [7:0] vOdd;
	} upPairT;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgbPixelT;

	typedef struct packed {
		rgbPixelT pixEven;
		rgbPixelT pixOdd;
	} rgbPairT;

	typedef enum logic [1:0] {
		LineIdle,
		LineFeed,
		LineFlush
	} lineStateT;

	// Symmetric six-tap interpolation filter, outer to inner
	localparam logic signed [31:0] Tap0 = 32'sd21;
	localparam logic signed [31:0] Tap1 = -32'sd52;
	localparam logic signed [31:0] Tap2 = 32'sd159;
	localparam logic signed [31:0] FilterRound = 32'sd128;
	localparam logic signed [31:0] FilterShift = 32'sd8;

	// Fixed-point colour matrix, scaled by 2^16
	localparam logic signed [31:0] CoefY = 32'sd76284;
	localparam logic signed [31:0] CoefRV = 32'sd104595;
	localparam logic signed [31:0] CoefGU = -32'sd25624;
	localparam logic signed [31:0] CoefGV = -32'sd53281;
	localparam logic signed [31:0] CoefBU = 32'sd132251;

	localparam logic signed [31:0] LumaOffset = 32'sd16;
	localparam logic signed [31:0] ChromaOffset = 32'sd128;
	localparam logic signed [31:0] MatrixShift = 32'sd16;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the YUV converter testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f sim.f \
	--top-module tbYuvConvert \
	-Mdir "$BUILD_DIR" \
	-o VtbYuvConvert

"./$BUILD_DIR/VtbYuvConvert" | tee "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim.f ====
hdl/yuvPkg.sv
hdl/pairFifo.sv
hdl/lineControl.sv
hdl/chromaUpsampler.sv
hdl/colorMatrix.sv
hdl/yuvConvertTop.sv
sim/yuvConvert_asserts.sv
sim/tbYuvConvert.sv

// ==== sim/tbYuvConvert.sv ====
module tbYuvConvert;

	localparam int FifoDepth = 4;
	localparam int OutCredits = 2;
	localparam int PairCountWidth = 8;
	// 30 cycles per pair and 100 per line summed over the five tests
	localparam int CycleLimit = 30 * (8 + 29 + 12 + 29 + 17) + 100 * 10;

	logic Clock;
	logic Resetn;
	logic yuvValid;
	yuvPkg::yuvPairT yuvData;
	logic yuvCredit;
	logic cfgWrite;
	logic [PairCountWidth-1:0] cfgPairs;
	logic lineBusy;
	logic rgbValid;
	yuvPkg::rgbPairT rgbData;
	logic rgbCredit;

	yuvPkg::yuvPairT lineBuf [64];
	yuvPkg::yuvPairT randStore [64];
	yuvPkg::rgbPairT expQ [$];
	yuvPkg::rgbPairT rxLog [256];
	int stallPattern [256];
	int randWidths [3] = '{4, 9, 16};
	int seed = 32'h50a9;
	int rxCount = 0;
	int returnedCount = 0;
	int creditPulses = 0;
	int pairsSent = 0;
	int mismatches = 0;
	int checkErrors = 0;
	int holdLeft = 0;
	bit stallMode = 1'b0;

	yuvConvertTop #(
		.FifoDepth(FifoDepth),
		.OutCredits(OutCredits),
		.PairCountWidth(PairCountWidth)
	) u_yuvConvertTop (
		.Clock(Clock),
		.Resetn(Resetn),
		.yuvValid(yuvValid),
		.yuvData(yuvData),
		.yuvCredit(yuvCredit),
		.cfgWrite(cfgWrite),
		.cfgPairs(cfgPairs),
		.lineBusy(lineBusy),
		.rgbValid(rgbValid),
		.rgbData(rgbData),
		.rgbCredit(rgbCredit)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	initial begin : watchdog
		int cycleCount;
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", CycleLimit);
		$display("Done: errors found");
		$finish;
	end

	// Outputs and credit pulses are sampled mid-cycle
	always @(negedge Clock) begin : compareOutputs
		yuvPkg::rgbPairT expPair;
		if (Resetn && yuvCredit)
			creditPulses++;
		if (Resetn && rgbValid) begin
			if (expQ.size() == 0) begin
				mismatches++;
				$display("Output pair arrived at %0t while no pair was expected", $time);
			end else begin
				expPair = expQ.pop_front();
				if (rgbData !== expPair) begin
					mismatches++;
					$display("FAILED at %0t: output %0d expected %h got %h", $time, rxCount,
						expPair, rgbData);
				end
			end
			rxLog[rxCount] = rgbData;
			rxCount++;
			if (rxCount - returnedCount > OutCredits) begin
				mismatches++;
				$display("Sink holds %0d unreturned pairs at %0t, more than the output credits",
					rxCount - returnedCount, $time);
			end
		end
	end

	// Sink hands back one credit per received pair and may stall
	initial begin : creditSink
		rgbCredit = 1'b0;
		forever begin
			@(posedge Clock);
			#2;
			if (holdLeft > 0) begin
				holdLeft--;
				rgbCredit = 1'b0;
			end else if (rxCount > returnedCount) begin
				rgbCredit = 1'b1;
				returnedCount++;
				if (stallMode)
					holdLeft = stallPattern[returnedCount % 256];
			end else begin
				rgbCredit = 1'b0;
			end
		end
	end

	function automatic int totalErrors();
		return mismatches + checkErrors;
	endfunction

	function automatic int upCredits();
		return FifoDepth - pairsSent + creditPulses;
	endfunction

	function automatic yuvPkg::yuvPairT makePair(input logic [7:0] y0, input logic [7:0] y1,
		input logic [7:0] u, input logic [7:0] v);
		yuvPkg::yuvPairT p;
		p.y0 = y0;
		p.y1 = y1;
		p.u = u;
		p.v = v;
		return p;
	endfunction

	function automatic logic [7:0] sat8(input int value);
		if (value < 0)
			return 8'd0;
		if (value > 255)
			return 8'd255;
		return 8'(value);
	endfunction

	// Tap weights for offsets -2..3 around the even sample
	function automatic int tapWeight(input int k);
		if (k == -2 || k == 3)
			return yuvPkg::Tap0;
		if (k == -1 || k == 2)
			return yuvPkg::Tap1;
		return yuvPkg::Tap2;
	endfunction

	// Odd chroma with the line edges held at the first and last sample
	function automatic logic [7:0] interpChroma(input int m, input int n, input bit pickV);
		int acc;
		int k;
		int idx;
		acc = yuvPkg::FilterRound;
		for (k = -2; k <= 3; k++) begin
			idx = (m + k < 0) ? 0 : ((m + k > n - 1) ? n - 1 : m + k);
			acc += tapWeight(k) * (pickV ? int'(lineBuf[idx].v) : int'(lineBuf[idx].u));
		end
		return sat8(acc >>> yuvPkg::FilterShift);
	endfunction

	function automatic yuvPkg::rgbPixelT toRgb(input logic [7:0] y, input logic [7:0] u,
		input logic [7:0] v);
		int dy;
		int du;
		int dv;
		int luma;
		yuvPkg::rgbPixelT px;
		dy = int'(y) - yuvPkg::LumaOffset;
		du = int'(u) - yuvPkg::ChromaOffset;
		dv = int'(v) - yuvPkg::ChromaOffset;
		luma = yuvPkg::CoefY * dy;
		px.r = sat8((luma + yuvPkg::CoefRV * dv) >>> yuvPkg::MatrixShift);
		px.g = sat8((luma + yuvPkg::CoefGU * du + yuvPkg::CoefGV * dv) >>> yuvPkg::MatrixShift);
		px.b = sat8((luma + yuvPkg::CoefBU * du) >>> yuvPkg::MatrixShift);
		return px;
	endfunction

	// Reference model for the line held in lineBuf
	function automatic void buildExpected(input int n);
		int m;
		yuvPkg::rgbPairT p;
		for (m = 0; m < n; m++) begin
			p.pixEven = toRgb(lineBuf[m].y0, lineBuf[m].u, lineBuf[m].v);
			p.pixOdd = toRgb(lineBuf[m].y1, interpChroma(m, n, 1'b0), interpChroma(m, n, 1'b1));
			expQ.push_back(p);
		end
	endfunction

	function automatic bit isGrey(input yuvPkg::rgbPixelT px);
		return px.r == px.g && px.g == px.b;
	endfunction

	task automatic configLine(input int n);
		while (lineBusy) begin
			@(posedge Clock);
			#2;
		end
		cfgWrite = 1'b1;
		cfgPairs = PairCountWidth'(n);
		@(posedge Clock);
		#2;
		cfgWrite = 1'b0;
	endtask

	// Upstream sends a pair only while it holds a credit
	task automatic streamLine(input int n);
		int i;
		i = 0;
		while (i < n) begin
			if (upCredits() > 0) begin
				yuvValid = 1'b1;
				yuvData = lineBuf[i];
				pairsSent++;
				i++;
			end else begin
				yuvValid = 1'b0;
			end
			@(posedge Clock);
			#2;
		end
		yuvValid = 1'b0;
	endtask

	task automatic runLine(input int n);
		buildExpected(n);
		configLine(n);
		streamLine(n);
	endtask

	task automatic waitIdle();
		@(negedge Clock);
		#1;
		while (lineBusy || expQ.size() != 0 || rxCount != returnedCount) begin
			@(negedge Clock);
			#1;
		end
		@(posedge Clock);
		#2;
	endtask

	task automatic playStored();
		int t;
		int i;
		int off;
		off = 0;
		for (t = 0; t < 3; t++) begin
			for (i = 0; i < randWidths[t]; i++)
				lineBuf[i] = randStore[off + i];
			runLine(randWidths[t]);
			waitIdle();
			off += randWidths[t];
		end
	endtask

	task automatic checkOutputs(input int base, input int n);
		if (rxCount - base != n) begin
			checkErrors++;
			$display("FAILED at %0t: %0d output pairs, expected %0d", $time, rxCount - base, n);
		end
	endtask

	task automatic checkByte(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected) begin
			checkErrors++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		if (totalErrors() == startErrors)
			$display("Test %s: passed", name);
		else
			$display("Test %s: failed with %0d errors", name, totalErrors() - startErrors);
	endtask

	initial begin : mainFlow
		int i;
		int base;
		int randBase;
		int startErrors;
		int sentBase;
		int pulseBase;
		Resetn = 1'b0;
		yuvValid = 1'b0;
		yuvData = '0;
		cfgWrite = 1'b0;
		cfgPairs = '0;
		for (i = 0; i < 256; i++)
			stallPattern[i] = int'($random(seed) & 32'hf);
		repeat (3) @(posedge Clock);
		#2;
		Resetn = 1'b1;

		// Grey ramp with neutral chroma
		startErrors = totalErrors();
		base = rxCount;
		for (i = 0; i < 8; i++)
			lineBuf[i] = makePair(8'(16 + i * 28), 8'(30 + i * 28), 8'd128, 8'd128);
		runLine(8);
		waitIdle();
		checkOutputs(base, 8);
		for (i = 0; i < 8; i++) begin
			if (!isGrey(rxLog[base + i].pixEven) || !isGrey(rxLog[base + i].pixOdd)) begin
				checkErrors++;
				$display("FAILED at %0t: neutral pair %0d has unequal channels", $time, i);
			end
		end
		reportTest("1 neutral chroma", startErrors);

		startErrors = totalErrors();
		randBase = rxCount;
		for (i = 0; i < 29; i++)
			randStore[i] = yuvPkg::yuvPairT'($random(seed));
		playStored();
		checkOutputs(randBase, 29);
		reportTest("2 random lines", startErrors);

		// Saturated red, clamped blue, then U swinging between the rails
		startErrors = totalErrors();
		base = rxCount;
		for (i = 0; i < 4; i++)
			lineBuf[i] = makePair(8'd255, 8'd255, 8'd128, 8'd255);
		for (i = 4; i < 8; i++)
			lineBuf[i] = makePair(8'd0, 8'd0, 8'd0, 8'd128);
		for (i = 8; i < 12; i++)
			lineBuf[i] = makePair(8'd128, 8'd128, (i % 4 == 1 || i % 4 == 2) ? 8'd255 : 8'd0,
				8'd128);
		runLine(12);
		waitIdle();
		checkOutputs(base, 12);
		for (i = 0; i < 4; i++)
			checkByte(rxLog[base + i].pixEven.r, 8'd255, "red of a saturated pixel");
		for (i = 4; i < 8; i++)
			checkByte(rxLog[base + i].pixEven.b, 8'd0, "blue of a clamped pixel");
		checkByte(rxLog[base + 9].pixOdd.b, 8'd255, "blue with odd U at its top limit");
		checkByte(rxLog[base + 11].pixOdd.b, 8'd0, "blue with odd U at its bottom limit");
		reportTest("3 clipping", startErrors);

		startErrors = totalErrors();
		base = rxCount;
		stallMode = 1'b1;
		playStored();
		stallMode = 1'b0;
		checkOutputs(base, 29);
		for (i = 0; i < 29; i++) begin
			if (rxLog[base + i] !== rxLog[randBase + i]) begin
				checkErrors++;
				$display("FAILED at %0t: stalled output %0d differs from the free run", $time, i);
			end
		end
		reportTest("4 back-pressure", startErrors);

		// Second line configured as soon as the first one leaves the FSM
		startErrors = totalErrors();
		base = rxCount;
		sentBase = pairsSent;
		pulseBase = creditPulses;
		for (i = 0; i < 6; i++)
			lineBuf[i] = yuvPkg::yuvPairT'($random(seed));
		runLine(6);
		for (i = 0; i < 11; i++)
			lineBuf[i] = yuvPkg::yuvPairT'($random(seed));
		runLine(11);
		waitIdle();
		checkOutputs(base, 17);
		if (creditPulses - pulseBase != pairsSent - sentBase) begin
			checkErrors++;
			$display("FAILED at %0t: %0d credit pulses for %0d pairs sent", $time,
				creditPulses - pulseBase, pairsSent - sentBase);
		end
		reportTest("5 credits and reconfiguration", startErrors);

		$display("Summary: %0d output pairs checked, %0d errors", rxCount, totalErrors());
		if (totalErrors() == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== sim/yuvConvert_asserts.sv ====
module yuvConvertAsserts (
	input logic Clock,
	input logic Resetn,
	input logic yuvValid,
	input logic yuvCredit,
	input logic cfgWrite,
	input logic lineBusy,
	input logic rgbValid
);

	logic [15:0] sentCount;
	logic [15:0] returnCount;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			sentCount <= '0;
			returnCount <= '0;
		end else begin
			if (yuvValid)
				sentCount <= sentCount + 16'd1;
			if (yuvCredit)
				returnCount <= returnCount + 16'd1;
		end
	end

	resetQuiet: assert property (@(posedge Clock) !Resetn |-> !rgbValid)
		else $error("rgbValid high while Resetn is low");

	// A credit only follows a pair that entered the FIFO
	creditBound: assert property (@(posedge Clock) disable iff (!Resetn)
		(returnCount + 16'(yuvCredit)) <= sentCount)
		else $error("more yuvCredit pulses than pairs sent");

	cfgIdleOnly: assert property (@(posedge Clock) disable iff (!Resetn) cfgWrite |-> !lineBusy)
		else $error("cfgWrite asserted while lineBusy is high");

	// Accepted configuration starts a line
	cfgStarts: assert property (@(posedge Clock) disable iff (!Resetn)
		cfgWrite && !lineBusy |=> lineBusy)
		else $error("lineBusy did not rise after cfgWrite");

endmodule

bind yuvConvertTop yuvConvertAsserts u_yuvConvertAsserts (
	.Clock(Clock),
	.Resetn(Resetn),
	.yuvValid(yuvValid),
	.yuvCredit(yuvCredit),
	.cfgWrite(cfgWrite),
	.lineBusy(lineBusy),
	.rgbValid(rgbValid)
);
